//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = execUnitTb
FILELIST = sources.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- alu.sv
module alu (
	input  aluPkg::aluWord  a,
	input  aluPkg::aluWord  b,
	input  aluPkg::aluOp    op,
	output aluPkg::aluWord  result,
	output aluPkg::aluFlags flags,
	// op is one of the two undefined codes
	output logic            illegal
);

	// adder outputs
	aluPkg::aluWord addSum;
	logic           addCarry;
	logic           addOverflow;

	// adder subtracts only for opSub
	logic           subSel;

	assign subSel = (op == aluPkg::opSub);

	// shared adder/subtractor
	aluAdder adder0 (
		.a        (a),
		.b        (b),
		.sub      (subSel),
		.sum      (addSum),
		.carry    (addCarry),
		.overflow (addOverflow)
	);

	// operation select and flag forming
	always_comb begin
		result         = '0;
		illegal        = 1'b0;
		flags.overflow = 1'b0;
		flags.carry    = 1'b0;

		case (op)
			aluPkg::opPassB: result = b;
			aluPkg::opAdd, aluPkg::opSub: begin
				result         = addSum;
				// V and C only mean something for add and sub
				flags.overflow = addOverflow;
				flags.carry    = addCarry;
			end
			aluPkg::opAnd: result = a & b;
			aluPkg::opOr:  result = a | b;
			aluPkg::opXor: result = a ^ b;
			// 001 and 111 leave the result at zero
			default: illegal = 1'b1;
		endcase

		// N and Z follow the selected result for every op
		flags.negative = result[aluPkg::dataWidth-1];
		flags.zero     = ~|result;
	end

endmodule

//--- aluAdder.sv
module aluAdder (
	input  aluPkg::aluWord a,
	input  aluPkg::aluWord b,
	// subtract when set, a - b as a + ~b + 1
	input  logic           sub,
	output aluPkg::aluWord sum,
	output logic           carry,
	output logic           overflow
);

	// b after optional inversion
	aluPkg::aluWord bAdj;

	// carry into each section, last entry is the final carry out
	logic [aluPkg::sectionCount:0] secCarry;

	// invert b for subtract, the +1 comes in as carry-in
	assign bAdj        = sub ? ~b : b;
	assign secCarry[0] = sub;

	genvar i;
	generate
		for (i = 0; i < aluPkg::sectionCount; i++) begin : gSection
			// section sums with carry bit on top
			// one assuming carry-in 0, one assuming carry-in 1
			logic [aluPkg::sectionWidth:0] sumLo;
			logic [aluPkg::sectionWidth:0] sumHi;

			assign sumLo = {1'b0, a[i*aluPkg::sectionWidth +: aluPkg::sectionWidth]}
				+ {1'b0, bAdj[i*aluPkg::sectionWidth +: aluPkg::sectionWidth]};
			assign sumHi = {1'b0, a[i*aluPkg::sectionWidth +: aluPkg::sectionWidth]}
				+ {1'b0, bAdj[i*aluPkg::sectionWidth +: aluPkg::sectionWidth]}
				+ {{aluPkg::sectionWidth{1'b0}}, 1'b1};

			// previous section's carry picks which precomputed sum is used
			assign sum[i*aluPkg::sectionWidth +: aluPkg::sectionWidth] = secCarry[i]
				? sumHi[aluPkg::sectionWidth-1:0]
				: sumLo[aluPkg::sectionWidth-1:0];
			assign secCarry[i+1] = secCarry[i]
				? sumHi[aluPkg::sectionWidth]
				: sumLo[aluPkg::sectionWidth];
		end
	endgenerate

	assign carry = secCarry[aluPkg::sectionCount];

	// signed overflow when both addends share a sign the sum lacks
	assign overflow = (a[aluPkg::dataWidth-1] == bAdj[aluPkg::dataWidth-1])
		&& (sum[aluPkg::dataWidth-1] != a[aluPkg::dataWidth-1]);

endmodule

//--- aluPkg.sv
package aluPkg;

	// datapath width, fixed by the instruction set
	localparam int dataWidth = 64;

	// carry-select adder is split into sections of this many bits
	localparam int sectionWidth = 16;

	// number of carry-select sections in one word
	localparam int sectionCount = dataWidth / sectionWidth;

	// one operand or result word
	typedef logic [dataWidth-1:0] aluWord;

	// ALU operation codes
	// 001 and 111 stay unassigned and decode as illegal in the ALU
	typedef enum logic [2:0] {
		opPassB = 3'b000,
		opAdd   = 3'b010,
		opSub   = 3'b011,
		opAnd   = 3'b100,
		opOr    = 3'b101,
		opXor   = 3'b110
	} aluOp;

	// condition flags in NZVC order
	typedef struct packed {
		// top bit of the result
		logic negative;
		// whole result is zero
		logic zero;
		// signed overflow, add and sub only
		logic overflow;
		// carry out of the top bit, add and sub only
		logic carry;
	} aluFlags;

endpackage

//--- execControl.sv
module execControl (
	input  logic             clk,
	input  logic             reset,
	// host side, four-phase req/ack
	input  execPkg::execCmd  cmd,
	input  logic             req,
	output logic             ack,
	output execPkg::execResp resp,
	// register file read ports
	output execPkg::regIndex rdAddrA,
	output execPkg::regIndex rdAddrB,
	input  aluPkg::aluWord   rdDataA,
	input  aluPkg::aluWord   rdDataB,
	// register file write port
	output logic             wrEn,
	output execPkg::regIndex wrAddr,
	output aluPkg::aluWord   wrData,
	// ALU input registers
	output aluPkg::aluWord   opA,
	output aluPkg::aluWord   opB,
	output aluPkg::aluOp     op,
	// ALU outputs, combinational from opA, opB and op
	input  aluPkg::aluWord   aluResult,
	input  aluPkg::aluFlags  aluFlags,
	input  logic             aluIllegal
);

	execPkg::ctrlState state;

	// command held for the whole transaction
	execPkg::execCmd cmdReg;

	// NZVC register
	aluPkg::aluFlags flagReg;

	// flag value after the command in stExec
	aluPkg::aluFlags nextFlags;

	// operand B before it is registered
	aluPkg::aluWord  opBSel;

	// zero-extended immediate
	aluPkg::aluWord  immExt;

	// read addresses come straight from the captured command
	assign rdAddrA = cmdReg.rn;
	assign rdAddrB = cmdReg.rm;

	assign immExt = {{(aluPkg::dataWidth - execPkg::immWidth){1'b0}}, cmdReg.imm};
	assign opBSel = cmdReg.useImm ? immExt : rdDataB;

	// write back only legal results, never into the zero register
	assign wrEn   = (state == execPkg::stExec) && !aluIllegal
		&& (cmdReg.rd != execPkg::zeroReg);
	assign wrAddr = cmdReg.rd;
	assign wrData = aluResult;

	// illegal ops leave the flag register alone even with setFlags
	assign nextFlags = (cmdReg.setFlags && !aluIllegal) ? aluFlags : flagReg;

	// ack is high for exactly the stDone state
	assign ack = (state == execPkg::stDone);

	// FSM, command capture, flags and response
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= execPkg::stIdle;
			cmdReg  <= '0;
			flagReg <= '0;
			resp    <= '0;
			op      <= aluPkg::opPassB;
		end else begin
			case (state)
				execPkg::stIdle: begin
					// edge k, take the command while the host holds it stable
					if (req) begin
						cmdReg <= cmd;
						state  <= execPkg::stRead;
					end
				end
				execPkg::stRead: begin
					// edge k+1, op goes with the operand registers
					op    <= cmdReg.op;
					state <= execPkg::stExec;
				end
				execPkg::stExec: begin
					// edge k+2, result and flags land together with ack
					resp.result  <= aluResult;
					resp.flags   <= nextFlags;
					resp.illegal <= aluIllegal;
					flagReg      <= nextFlags;
					state        <= execPkg::stDone;
				end
				execPkg::stDone: begin
					// hold while req is high
					if (!req) begin
						state <= execPkg::stIdle;
					end
				end
				default: state <= execPkg::stIdle;
			endcase
		end
	end

	// ALU operand registers, loaded at the end of stRead
	always_ff @(posedge clk) begin
		if (state == execPkg::stRead) begin
			opA <= rdDataA;
			opB <= opBSel;
		end
	end

	// host sees ack drop only after it has dropped req
	property pAckHold;
		@(posedge clk) disable iff (reset)
		(ack && req) |=> ack;
	endproperty

	aAckHold: assert property (pAckHold)
		else $error("execControl: ack dropped while req still high");

	// rd, op and setFlags must not move under an operation in flight
	property pCmdStable;
		@(posedge clk) disable iff (reset)
		(state != execPkg::stIdle) |=> $stable(cmdReg);
	endproperty

	aCmdStable: assert property (pCmdStable)
		else $error("execControl: captured command changed outside idle");

endmodule

//--- execPkg.sv
package execPkg;

	// size of the register file
	localparam int regCount = 32;

	// register index width
	typedef logic [4:0] regIndex;

	// this register always reads zero and ignores writes
	localparam regIndex zeroReg = 5'd31;

	// immediate field width
	localparam int immWidth = 12;

	// raw immediate as carried in a command
	typedef logic [immWidth-1:0] immField;

	// one command from the host
	// 32 bits in total
	typedef struct packed {
		// ALU operation
		aluPkg::aluOp op;
		// destination register
		regIndex rd;
		// first source for operand A
		regIndex rn;
		// second source for operand B unless useImm is set
		regIndex rm;
		// zero-extended into operand B when useImm is set
		immField imm;
		logic useImm;
		// update the NZVC register with this result
		logic setFlags;
	} execCmd;

	// response returned with ack
	// 69 bits in total
	typedef struct packed {
		aluPkg::aluWord result;
		// flag register contents after this command
		aluPkg::aluFlags flags;
		// operation code was not a defined one
		logic illegal;
	} execResp;

	// handshake and sequencing states
	typedef enum logic [1:0] {
		// waiting for req
		stIdle,
		// register file read and operands into ALU input registers
		stRead,
		// ALU result ready for write-back and flags update
		stExec,
		// ack high until the host drops req
		stDone
	} ctrlState;

endpackage

//--- execUnit.sv
module execUnit (
	input  logic             clk,
	input  logic             reset,
	// host command and handshake
	input  execPkg::execCmd  cmd,
	input  logic             req,
	output logic             ack,
	output execPkg::execResp resp
);

	// register file ports
	execPkg::regIndex rdAddrA;
	execPkg::regIndex rdAddrB;
	aluPkg::aluWord   rdDataA;
	aluPkg::aluWord   rdDataB;
	logic             wrEn;
	execPkg::regIndex wrAddr;
	aluPkg::aluWord   wrData;

	// ALU inputs from the control's operand registers
	aluPkg::aluWord   opA;
	aluPkg::aluWord   opB;
	aluPkg::aluOp     op;

	// ALU outputs back to control
	aluPkg::aluWord   aluResult;
	aluPkg::aluFlags  aluFlags;
	logic             aluIllegal;

	// sequencing, operand select, write-back and flags
	execControl control0 (
		.clk        (clk),
		.reset      (reset),
		.cmd        (cmd),
		.req        (req),
		.ack        (ack),
		.resp       (resp),
		.rdAddrA    (rdAddrA),
		.rdAddrB    (rdAddrB),
		.rdDataA    (rdDataA),
		.rdDataB    (rdDataB),
		.wrEn       (wrEn),
		.wrAddr     (wrAddr),
		.wrData     (wrData),
		.opA        (opA),
		.opB        (opB),
		.op         (op),
		.aluResult  (aluResult),
		.aluFlags   (aluFlags),
		.aluIllegal (aluIllegal)
	);

	// 32 x 64 registers, x31 reads zero
	regFile regFile0 (
		.clk     (clk),
		.reset   (reset),
		.rdAddrA (rdAddrA),
		.rdAddrB (rdAddrB),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.wrEn    (wrEn),
		.wrAddr  (wrAddr),
		.wrData  (wrData)
	);

	// combinational ALU
	alu alu0 (
		.a       (opA),
		.b       (opB),
		.op      (op),
		.result  (aluResult),
		.flags   (aluFlags),
		.illegal (aluIllegal)
	);

endmodule

//--- execUnitTb.sv
module execUnitTb;

	// handshake waits give up after this many clock cycles
	localparam int timeoutCycles = 50;

	logic clk;
	logic reset;
	execPkg::execCmd cmd;
	logic req;
	logic ack;
	execPkg::execResp resp;

	// reference model of the architectural state
	logic [63:0] modelRegs [32];
	logic [3:0] modelFlags;

	int errors;
	int checks;
	// set once a handshake stalls so later commands are skipped
	logic hung;
	string testName;
	logic [31:0] lfsr;

	// response captured while ack was high
	execPkg::execResp lastResp;
	aluPkg::aluFlags savedFlags;

	execUnit dut0 (
		.clk   (clk),
		.reset (reset),
		.cmd   (cmd),
		.req   (req),
		.ack   (ack),
		.resp  (resp)
	);

	always #20 clk = ~clk;

	task automatic check(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("error %s %s: expected %h actual %h", testName, what, expected, actual);
		end
	endtask

	// taps for x^32 + x^22 + x^2 + x + 1 with the new bit shifted in at the bottom
	function automatic logic lfsrBit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] randBits(input int count);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < count; i++) begin
			val = {val[30:0], lfsrBit()};
		end
		return val;
	endfunction

	// expected ALU outcome with vc as {overflow, carry}
	task automatic modelOp(input logic [2:0] opCode, input logic [63:0] a,
		input logic [63:0] b, output logic [63:0] res, output logic [1:0] vc,
		output logic ill);
		logic [64:0] wide;
		res = '0;
		vc = 2'b00;
		ill = 1'b0;
		case (opCode)
			3'b000: res = b;
			3'b010: begin
				wide = {1'b0, a} + {1'b0, b};
				res = wide[63:0];
				vc = {(a[63] == b[63]) && (res[63] != a[63]), wide[64]};
			end
			3'b011: begin
				// a + ~b + 1 where carry set means no borrow
				wide = {1'b0, a} + {1'b0, ~b} + 65'd1;
				res = wide[63:0];
				vc = {(a[63] != b[63]) && (res[63] != a[63]), wide[64]};
			end
			3'b100: res = a & b;
			3'b101: res = a | b;
			3'b110: res = a ^ b;
			// 001 and 111
			default: ill = 1'b1;
		endcase
	endtask

	// one full four-phase transaction checked against the model
	task automatic runCmd(input logic [2:0] opCode, input logic [4:0] rd,
		input logic [4:0] rn, input logic [4:0] rm, input logic [11:0] imm,
		input logic useImm, input logic setFlags);
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] expResult;
		logic [1:0] vc;
		logic expIllegal;
		logic [3:0] expFlags;
		int cycles;
		if (hung) return;
		a = (rn == execPkg::zeroReg) ? 64'd0 : modelRegs[rn];
		b = useImm ? {52'd0, imm} : ((rm == execPkg::zeroReg) ? 64'd0 : modelRegs[rm]);
		modelOp(opCode, a, b, expResult, vc, expIllegal);
		expFlags = (setFlags && !expIllegal)
			? {expResult[63], expResult == 64'd0, vc} : modelFlags;

		@(negedge clk);
		cmd = {opCode, rd, rn, rm, imm, useImm, setFlags};
		req = 1'b1;
		cycles = 0;
		while (!ack && cycles < timeoutCycles) begin
			@(negedge clk);
			cycles++;
		end
		if (!ack) begin
			$display("%s: ack never rose after req was raised", testName);
			errors++;
			hung = 1'b1;
			req = 1'b0;
			return;
		end
		// resp is valid and stable while ack is high
		lastResp = resp;
		req = 1'b0;
		cycles = 0;
		while (ack && cycles < timeoutCycles) begin
			@(negedge clk);
			cycles++;
		end
		if (ack) begin
			$display("%s: ack stayed high after req was dropped", testName);
			errors++;
			hung = 1'b1;
			return;
		end

		check("result", expResult, lastResp.result);
		check("flags", 64'(expFlags), 64'(lastResp.flags));
		check("illegal", 64'(expIllegal), 64'(lastResp.illegal));
		if (!expIllegal && rd != execPkg::zeroReg) begin
			modelRegs[rd] = expResult;
		end
		modelFlags = expFlags;
	endtask

	// add of r and immediate 0 into x31 returns the register unchanged
	task automatic readBack(input logic [4:0] r);
		runCmd(3'b010, 5'd31, r, 5'd31, 12'd0, 1'b1, 1'b0);
	endtask

	task automatic moveImmediates();
		testName = "moves";
		runCmd(3'b000, 5'd0, 5'd31, 5'd31, 12'h123, 1'b1, 1'b0);
		runCmd(3'b000, 5'd1, 5'd31, 5'd31, 12'hfff, 1'b1, 1'b0);
		runCmd(3'b000, 5'd2, 5'd31, 5'd31, 12'h800, 1'b1, 1'b0);
		runCmd(3'b000, 5'd30, 5'd31, 5'd31, 12'h5a5, 1'b1, 1'b0);
		// write to x31 must vanish
		runCmd(3'b000, 5'd31, 5'd31, 5'd31, 12'h7ff, 1'b1, 1'b0);
		readBack(5'd0);
		readBack(5'd1);
		readBack(5'd2);
		readBack(5'd30);
		readBack(5'd31);
		check("x31 reads zero", 64'd0, lastResp.result);
	endtask

	task automatic addSubFlags();
		testName = "addSub";
		// x1 = 7000 built from two immediates
		runCmd(3'b000, 5'd1, 5'd31, 5'd31, 12'd4000, 1'b1, 1'b0);
		runCmd(3'b010, 5'd1, 5'd1, 5'd31, 12'd3000, 1'b1, 1'b0);
		runCmd(3'b010, 5'd2, 5'd1, 5'd31, 12'd1888, 1'b1, 1'b1);
		check("7000+1888", 64'd8888, lastResp.result);
		check("7000+1888 nzvc", 64'd0, 64'(lastResp.flags));
		// 6999 - 6999
		runCmd(3'b011, 5'd3, 5'd1, 5'd31, 12'd1, 1'b1, 1'b0);
		runCmd(3'b011, 5'd4, 5'd3, 5'd3, 12'd0, 1'b0, 1'b1);
		check("6999-6999 z", 64'd1, 64'(lastResp.flags.zero));
		runCmd(3'b011, 5'd5, 5'd31, 5'd31, 12'd124, 1'b1, 1'b1);
		check("0-124 n", 64'd1, 64'(lastResp.flags.negative));
		// x6 all ones then wrap to zero
		runCmd(3'b011, 5'd6, 5'd31, 5'd31, 12'd1, 1'b1, 1'b0);
		runCmd(3'b010, 5'd7, 5'd6, 5'd31, 12'd1, 1'b1, 1'b1);
		check("ones+1 c", 64'd1, 64'(lastResp.flags.carry));
		check("ones+1 z", 64'd1, 64'(lastResp.flags.zero));
		// no shifts so double 1 up to the sign bit then step back to max positive
		runCmd(3'b000, 5'd8, 5'd31, 5'd31, 12'd1, 1'b1, 1'b0);
		for (int i = 0; i < 63; i++) begin
			runCmd(3'b010, 5'd8, 5'd8, 5'd8, 12'd0, 1'b0, 1'b0);
		end
		runCmd(3'b011, 5'd9, 5'd8, 5'd31, 12'd1, 1'b1, 1'b0);
		runCmd(3'b010, 5'd9, 5'd9, 5'd31, 12'd1, 1'b1, 1'b1);
		check("max+1 v", 64'd1, 64'(lastResp.flags.overflow));
		check("max+1 n", 64'd1, 64'(lastResp.flags.negative));
	endtask

	task automatic logicOps();
		testName = "logic";
		// x10 = ...fff0
		runCmd(3'b110, 5'd10, 5'd6, 5'd31, 12'h00f, 1'b1, 1'b0);
		runCmd(3'b100, 5'd11, 5'd6, 5'd10, 12'd0, 1'b0, 1'b1);
		check("and", 64'hffff_ffff_ffff_fff0, lastResp.result);
		check("and vc", 64'd0, 64'({lastResp.flags.overflow, lastResp.flags.carry}));
		runCmd(3'b101, 5'd12, 5'd6, 5'd10, 12'd0, 1'b0, 1'b1);
		check("or", 64'hffff_ffff_ffff_ffff, lastResp.result);
		check("or vc", 64'd0, 64'({lastResp.flags.overflow, lastResp.flags.carry}));
		runCmd(3'b110, 5'd13, 5'd6, 5'd10, 12'd0, 1'b0, 1'b1);
		check("xor", 64'h0000_0000_0000_000f, lastResp.result);
		check("xor vc", 64'd0, 64'({lastResp.flags.overflow, lastResp.flags.carry}));
	endtask

	task automatic flagRetention();
		testName = "retain";
		runCmd(3'b011, 5'd14, 5'd31, 5'd31, 12'd1, 1'b1, 1'b1);
		savedFlags = modelFlags;
		runCmd(3'b010, 5'd15, 5'd31, 5'd31, 12'd77, 1'b1, 1'b0);
		check("flags kept", 64'(savedFlags), 64'(lastResp.flags));
		readBack(5'd15);
		check("x15 written", 64'd77, lastResp.result);
	endtask

	task automatic illegalCodes();
		testName = "illegal";
		runCmd(3'b000, 5'd16, 5'd31, 5'd31, 12'h3c3, 1'b1, 1'b0);
		savedFlags = modelFlags;
		runCmd(3'b001, 5'd16, 5'd6, 5'd10, 12'd0, 1'b0, 1'b1);
		check("001 result", 64'd0, lastResp.result);
		check("001 illegal", 64'd1, 64'(lastResp.illegal));
		runCmd(3'b111, 5'd16, 5'd6, 5'd31, 12'hfff, 1'b1, 1'b1);
		check("111 result", 64'd0, lastResp.result);
		check("111 illegal", 64'd1, 64'(lastResp.illegal));
		readBack(5'd16);
		check("x16 kept", 64'h3c3, lastResp.result);
		check("flags kept", 64'(savedFlags), 64'(lastResp.flags));
	endtask

	task automatic randomCmds();
		logic [2:0] opCode;
		logic [4:0] rd;
		logic [4:0] rn;
		logic [4:0] rm;
		logic [11:0] imm;
		logic useImm;
		logic setFlags;
		testName = "random";
		for (int n = 0; n < 40; n++) begin
			opCode = 3'(randBits(3));
			rd = 5'(randBits(5));
			rn = 5'(randBits(5));
			rm = 5'(randBits(5));
			imm = 12'(randBits(12));
			useImm = 1'(randBits(1));
			setFlags = 1'(randBits(1));
			runCmd(opCode, rd, rn, rm, imm, useImm, setFlags);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		req = 1'b0;
		cmd = '0;
		errors = 0;
		checks = 0;
		hung = 1'b0;
		lfsr = 32'h3dcf;
		modelFlags = '0;
		savedFlags = '0;
		lastResp = '0;
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		testName = "reset";
		check("ack", 64'd0, 64'(ack));
		check("resp", 64'd0, 64'(resp));

		moveImmediates();
		addSubFlags();
		logicOps();
		flagRetention();
		illegalCodes();
		randomCmds();

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- regFile.sv
module regFile (
	input  logic            clk,
	input  logic            reset,
	// two combinational read ports
	input  execPkg::regIndex rdAddrA,
	input  execPkg::regIndex rdAddrB,
	output aluPkg::aluWord   rdDataA,
	output aluPkg::aluWord   rdDataB,
	// one write port, written at the clock edge
	input  logic            wrEn,
	input  execPkg::regIndex wrAddr,
	input  aluPkg::aluWord   wrData
);

	// register storage
	aluPkg::aluWord regs [execPkg::regCount];

	// all registers come out of reset at zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < execPkg::regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// register 31 is hard-wired to zero on both read ports
	assign rdDataA = (rdAddrA == execPkg::zeroReg) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == execPkg::zeroReg) ? '0 : regs[rdAddrB];

	// control must filter writes to the zero register before they get here
	// a write there would be harmless on reads but means the rd gating broke
	property pNoZeroRegWrite;
		@(posedge clk) disable iff (reset)
		wrEn |-> (wrAddr != execPkg::zeroReg);
	endproperty

	aNoZeroRegWrite: assert property (pNoZeroRegWrite)
		else $error("regFile: write presented to zero register");

endmodule

//--- sources.f
aluPkg.sv
execPkg.sv
aluAdder.sv
alu.sv
regFile.sv
execControl.sv
execUnit.sv
execUnitTb.sv
